// ==== common/client_pkg.sv ====
////////////////////
// Client byte interface sizes and latency
// Common to the framer, the client model and the capture block
////////////////////
package client_pkg;

	// Byte lane of idata and odata
	localparam int DATA_W = 8;

	// len_c and packet length width
	localparam int LEN_W = 11;

	// Cycles from a byte on idata to the same byte on odata
	localparam int N_LAT = 3;

	// len_c on first payload byte is data_len plus this
	localparam int LEN_OFFSET = 8;

endpackage

// ==== common/frame_pkg.sv ====
////////////////////
// Framer timing and buffer sizes
// Also holds the framer state encoding
////////////////////
package frame_pkg;

	// Packet buffer depth in bytes, same for the reply buffer
	localparam int MSG_MAX = 96;
	localparam int ADDR_W = $clog2(MSG_MAX);  // 7 bits for 96 bytes

	// raw_l only cycles around the payload
	localparam int PREAMBLE_CNT = 18;
	localparam int TAIL_CNT = 4;

	// Framer phases
	typedef enum logic [1:0] {
		IDLE,      // Waiting for start
		PREAMBLE,  // raw_l high, no data
		PAYLOAD,   // raw_l and raw_s high, bytes on idata
		TAIL       // raw_l high after the payload
	} frame_state_e;

endpackage

// ==== framer/packet_framer.sv ====
////////////////////
// Packet framer
// Holds packet bytes and plays them out on the client interface
////////////////////
module packet_framer import client_pkg::*, frame_pkg::*; (
	input  logic              clk,
	input  logic              reset,
	input  logic              start,      // One-cycle launch pulse
	input  logic [LEN_W-1:0]  data_len,   // Payload length for this packet
	input  logic              load_we,
	input  logic [ADDR_W-1:0] load_addr,
	input  logic [DATA_W-1:0] load_data,
	output logic              raw_l,      // Preamble + payload + tail
	output logic              raw_s,      // Payload only
	output logic [LEN_W-1:0]  len_c,      // Countdown during payload
	output logic [DATA_W-1:0] idata,
	output logic              busy
);

	logic [DATA_W-1:0] pkt_mem [MSG_MAX];  // Packet byte buffer
	frame_state_e      state;
	logic [LEN_W-1:0]  cnt;       // Cycle count inside a phase, payload index in PAYLOAD
	logic [LEN_W-1:0]  len_q;     // Length captured at start
	logic              start_ok;

	// A start while a packet is going out is dropped
	assign start_ok = start & ~busy;

	// Buffer load port, out-of-range addresses are ignored
	always_ff @(posedge clk) begin
		if (load_we && (load_addr < ADDR_W'(MSG_MAX)))
			pkt_mem[load_addr] <= load_data;
	end

	// Phase sequencer
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			cnt <= '0;
			len_q <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (start_ok) begin
						state <= PREAMBLE;
						cnt <= '0;
						len_q <= data_len;  // Hold length for the whole packet
					end
				end
				PREAMBLE: begin
					if (cnt == LEN_W'(PREAMBLE_CNT - 1)) begin
						cnt <= '0;
						// Empty packet goes straight to the tail
						if (len_q == '0)
							state <= TAIL;
						else
							state <= PAYLOAD;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				PAYLOAD: begin
					if (cnt == len_q - 1'b1) begin
						cnt <= '0;
						state <= TAIL;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				TAIL: begin
					if (cnt == LEN_W'(TAIL_CNT - 1)) begin
						cnt <= '0;
						state <= IDLE;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Strobes lag the state by one cycle, so raw_l rises after the edge following start
	always_ff @(posedge clk) begin
		if (reset) begin
			raw_l <= 1'b0;
			raw_s <= 1'b0;
		end else begin
			raw_l <= (state != IDLE);
			raw_s <= (state == PAYLOAD);
		end
	end

	// Data and countdown, aligned with raw_s
	always_ff @(posedge clk) begin
		if (state == PAYLOAD) begin
			idata <= pkt_mem[cnt[ADDR_W-1:0]];
			len_c <= len_q + LEN_W'(LEN_OFFSET) - cnt;  // data_len+8-i
		end else begin
			idata <= '0;
			len_c <= '0;
		end
	end

	// Covers the launch cycle and the last tail cycle too
	assign busy = (state != IDLE) | raw_l;

endmodule

// ==== rtl/payload_scrambler.sv ====
////////////////////
// Client model: keyed payload with fixed latency
// Also sums the raw payload bytes per packet
////////////////////
module payload_scrambler import client_pkg::*; (
	input  logic              clk,
	input  logic              reset,
	input  logic              raw_l,
	input  logic              raw_s,
	input  logic [DATA_W-1:0] idata,
	input  logic [DATA_W-1:0] key,         // Run-time XOR key
	output logic [DATA_W-1:0] odata,
	output logic [DATA_W-1:0] csum,        // 8-bit sum of payload
	output logic              csum_valid   // One-cycle report strobe
);

	logic [DATA_W-1:0] pipe [N_LAT];  // Latency stages
	logic [DATA_W-1:0] sum;
	logic              raw_l_d;
	logic              raw_s_d;
	logic              l_rise;
	logic              s_fall;

	// Key goes on at the first stage, later stages only delay
	always_ff @(posedge clk) begin
		pipe[0] <= idata ^ key;
		for (int i = 1; i < N_LAT; i++)
			pipe[i] <= pipe[i-1];
	end
	assign odata = pipe[N_LAT-1];

	assign l_rise = raw_l & ~raw_l_d;  // Start of a new packet
	assign s_fall = raw_s_d & ~raw_s;  // Payload just ended

	always_ff @(posedge clk) begin
		if (reset) begin
			raw_l_d <= 1'b0;
			raw_s_d <= 1'b0;
			csum_valid <= 1'b0;
		end else begin
			raw_l_d <= raw_l;
			raw_s_d <= raw_s;
			csum_valid <= s_fall;
		end
	end

	// Accumulator, wraps at 8 bits
	always_ff @(posedge clk) begin
		if (l_rise)
			sum <= '0;  // Preamble comes first, no payload byte yet
		else if (raw_s)
			sum <= sum + idata;
		if (s_fall)
			csum <= sum;  // Held until the next packet ends
	end

endmodule

// ==== rtl/reply_capture.sv ====
////////////////////
// Reply capture
// Rebuilds the output strobe and stores the returned bytes
////////////////////
module reply_capture import client_pkg::*, frame_pkg::*; (
	input  logic              clk,
	input  logic              reset,
	input  logic              raw_s,
	input  logic [DATA_W-1:0] odata,
	input  logic [ADDR_W-1:0] rd_addr,
	output logic              tx_strobe,  // raw_s delayed by N_LAT
	output logic [DATA_W-1:0] rd_data,
	output logic [LEN_W-1:0]  reply_len,
	output logic              done
);

	logic [DATA_W-1:0] reply_mem [MSG_MAX];
	logic [N_LAT-1:0]  strobe_sr;   // Delay line for raw_s
	logic [LEN_W-1:0]  wr_ptr;      // Bytes stored so far
	logic              tx_d;
	logic              tx_fall;

	// Shift register timing matches the client pipeline depth
	always_ff @(posedge clk) begin
		if (reset)
			strobe_sr <= '0;
		else
			strobe_sr <= {strobe_sr[N_LAT-2:0], raw_s};
	end
	assign tx_strobe = strobe_sr[N_LAT-1];

	assign tx_fall = tx_d & ~tx_strobe;  // Last reply byte was the previous cycle

	// Store while the rebuilt strobe is high, drop bytes past the buffer end
	always_ff @(posedge clk) begin
		if (tx_strobe && (wr_ptr < LEN_W'(MSG_MAX)))
			reply_mem[wr_ptr[ADDR_W-1:0]] <= odata;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			tx_d <= 1'b0;
			wr_ptr <= '0;
			done <= 1'b0;
		end else begin
			tx_d <= tx_strobe;
			done <= tx_fall;
			if (tx_fall)
				wr_ptr <= '0;  // Ready for the next packet
			else if (tx_strobe)
				wr_ptr <= wr_ptr + 1'b1;
		end
	end

	// Length is latched with done and held
	always_ff @(posedge clk) begin
		if (tx_fall)
			reply_len <= wr_ptr;
	end

	assign rd_data = reply_mem[rd_addr];  // Asynchronous read port

endmodule

// ==== rtl/client_loop_top.sv ====
////////////////////
// Client loop top
// Framer into scrambler into reply capture
////////////////////
module client_loop_top import client_pkg::*, frame_pkg::*; (
	input  logic              clk,
	input  logic              reset,
	input  logic              start,
	input  logic [LEN_W-1:0]  data_len,
	input  logic              load_we,
	input  logic [ADDR_W-1:0] load_addr,
	input  logic [DATA_W-1:0] load_data,
	input  logic [DATA_W-1:0] key,
	input  logic [ADDR_W-1:0] rd_addr,
	output logic              busy,
	output logic              raw_l,      // Observation of the client strobes
	output logic              raw_s,
	output logic [LEN_W-1:0]  len_c,
	output logic              tx_strobe,
	output logic [DATA_W-1:0] csum,
	output logic              csum_valid,
	output logic [DATA_W-1:0] rd_data,
	output logic [LEN_W-1:0]  reply_len,
	output logic              done
);

	logic [DATA_W-1:0] idata;  // Framer to client
	logic [DATA_W-1:0] odata;  // Client to capture

	packet_framer u_framer (
		.clk       (clk),
		.reset     (reset),
		.start     (start),
		.data_len  (data_len),
		.load_we   (load_we),
		.load_addr (load_addr),
		.load_data (load_data),
		.raw_l     (raw_l),
		.raw_s     (raw_s),
		.len_c     (len_c),
		.idata     (idata),
		.busy      (busy)
	);

	payload_scrambler u_scrambler (
		.clk        (clk),
		.reset      (reset),
		.raw_l      (raw_l),
		.raw_s      (raw_s),
		.idata      (idata),
		.key        (key),
		.odata      (odata),
		.csum       (csum),
		.csum_valid (csum_valid)
	);

	reply_capture u_capture (
		.clk       (clk),
		.reset     (reset),
		.raw_s     (raw_s),
		.odata     (odata),
		.rd_addr   (rd_addr),
		.tx_strobe (tx_strobe),
		.rd_data   (rd_data),
		.reply_len (reply_len),
		.done      (done)
	);

endmodule

// ==== dv/client_loop_tb.sv ====
////////////////////
// Client loop testbench
// Directed tests of framing, keyed reply, latency and checksum
////////////////////
module client_loop_tb import client_pkg::*, frame_pkg::*; ();

	localparam int WAIT_MAX = 400;  // Cycle limit for any single wait

	logic              clk;
	logic              reset;
	logic              start;
	logic [LEN_W-1:0]  data_len;
	logic              load_we;
	logic [ADDR_W-1:0] load_addr;
	logic [DATA_W-1:0] load_data;
	logic [DATA_W-1:0] key;
	logic [ADDR_W-1:0] rd_addr;
	logic              busy;
	logic              raw_l;
	logic              raw_s;
	logic [LEN_W-1:0]  len_c;
	logic              tx_strobe;
	logic [DATA_W-1:0] csum;
	logic              csum_valid;
	logic [DATA_W-1:0] rd_data;
	logic [LEN_W-1:0]  reply_len;
	logic              done;

	logic [DATA_W-1:0] model [MSG_MAX];  // Bytes as loaded into the framer
	logic [31:0]       lfsr;
	int                errors;
	int                test_errs;
	int                tests;
	int                first_s;    // Cycle of first raw_s in the last run
	int                first_tx;   // Cycle of first tx_strobe
	int                l_rises;    // raw_l rising edges seen
	bit                got_done;
	bit                got_csum;
	logic [DATA_W-1:0] csum_got;
	logic [LEN_W-1:0]  len_got;

	client_loop_top u_dut (.*);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// Galois LFSR, one shift per bit
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {1'b0, s[31:1]} ^ (s[0] ? 32'h80200003 : 32'h0);
	endfunction

	function automatic logic [7:0] rand_byte();
		logic [7:0] b;
		b = '0;
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_step(lfsr);
			b = {b[6:0], lfsr[0]};  // Take the new low bit
		end
		return b;
	endfunction

	// Expected checksum, wraps at 8 bits
	function automatic logic [7:0] model_sum(input int len);
		logic [7:0] s;
		s = '0;
		for (int i = 0; i < len; i++)
			s = s + model[i];
		return s;
	endfunction

	task automatic step();
		@(posedge clk);
		#1;  // Drive and sample away from the edge
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			$display("Error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
			test_errs++;
		end
	endtask

	task automatic check_true(input bit cond, input string what);
		assert (cond) else begin
			$display("At %0t: %s", $time, what);
			test_errs++;
		end
	endtask

	task automatic end_test(input string name);
		$display("Test %s done with %0d errors", name, test_errs);
		errors += test_errs;
		tests++;
		test_errs = 0;
	endtask

	task automatic load_packet(input int len);
		for (int i = 0; i < len; i++) begin
			model[i] = rand_byte();
			load_we = 1'b1;
			load_addr = ADDR_W'(i);
			load_data = model[i];
			step();
		end
		load_we = 1'b0;
	endtask

	task automatic launch(input int len);
		data_len = LEN_W'(len);
		start = 1'b1;
		step();  // Accept edge
		start = 1'b0;
	endtask

	// Follows one packet until done, with an extra start at cycle stray_at
	task automatic run_packet(input int len, input int stray_at);
		bit prev_l;
		prev_l = 1'b0;
		first_s = -1;
		first_tx = -1;
		l_rises = 0;
		got_done = 1'b0;
		got_csum = 1'b0;
		launch(len);
		for (int n = 0; n < WAIT_MAX && !got_done; n++) begin
			if (raw_l && !prev_l)
				l_rises++;
			prev_l = raw_l;
			if (raw_s && first_s < 0)
				first_s = n;
			if (tx_strobe && first_tx < 0)
				first_tx = n;
			if (csum_valid) begin
				got_csum = 1'b1;
				csum_got = csum;
			end
			start = (n == stray_at);  // Should be dropped by the framer
			if (n == stray_at) begin
				data_len = LEN_W'(MSG_MAX);
				check_true(busy, "busy low when the extra start was given");
			end
			if (done) begin
				got_done = 1'b1;
				len_got = reply_len;
			end else begin
				step();
			end
		end
		start = 1'b0;
		check_true(got_done, "timed out waiting for done");
	endtask

	task automatic check_reply(input int len);
		check_value("reply_len", len_got, len);
		for (int i = 0; i < len; i++) begin
			rd_addr = ADDR_W'(i);
			step();
			check_value("rd_data", rd_data, model[i] ^ key);  // Client keys every byte
		end
	endtask

	task automatic test_reset();
		check_value("busy", busy, 0);
		check_value("raw_l", raw_l, 0);
		check_value("raw_s", raw_s, 0);
		check_value("tx_strobe", tx_strobe, 0);
		check_value("done", done, 0);
		check_value("csum_valid", csum_valid, 0);
		end_test("reset");
	endtask

	task automatic test_framing();
		int pre;
		int pay;
		int tail;
		int n;
		pre = 0;
		pay = 0;
		tail = 0;
		load_packet(20);
		launch(20);
		for (n = 0; n < WAIT_MAX && !raw_l; n++)
			step();
		check_true(raw_l, "raw_l never rose");
		for (n = 0; n < WAIT_MAX && raw_l && !raw_s; n++) begin
			pre++;
			step();
		end
		for (n = 0; n < WAIT_MAX && raw_s; n++) begin
			check_value("len_c", len_c, 20 + LEN_OFFSET - pay);  // Counts down per byte
			pay++;
			step();
		end
		for (n = 0; n < WAIT_MAX && raw_l; n++) begin
			tail++;
			step();
		end
		check_value("preamble cycles", pre, PREAMBLE_CNT);
		check_value("payload cycles", pay, 20);
		check_value("tail cycles", tail, TAIL_CNT);
		for (n = 0; n < WAIT_MAX && !done; n++)
			step();
		check_true(done, "timed out waiting for done after framing");
		end_test("framing");
	endtask

	task automatic test_reply();
		int len;
		key = rand_byte();
		len = int'(rand_byte()) % MSG_MAX + 1;
		load_packet(len);
		run_packet(len, -1);
		check_reply(len);
		end_test("reply");
	endtask

	task automatic test_latency();
		load_packet(12);
		run_packet(12, -1);
		check_true(first_s >= 0 && first_tx >= 0, "raw_s or tx_strobe never seen");
		check_value("tx_strobe delay", first_tx - first_s, N_LAT);
		end_test("latency");
	endtask

	task automatic test_checksum();
		int len;
		len = int'(rand_byte()) % MSG_MAX + 1;
		load_packet(len);
		run_packet(len, -1);
		check_true(got_csum, "csum_valid never pulsed");
		check_value("csum", csum_got, model_sum(len));
		end_test("checksum");
	endtask

	task automatic test_back_to_back();
		int n;
		key = rand_byte();
		load_packet(10);
		// Extra start on the last tail cycle, FSM already idle but raw_l still high
		run_packet(10, PREAMBLE_CNT + 10 + TAIL_CNT);
		check_value("raw_l rises", l_rises, 1);
		for (n = 0; n < PREAMBLE_CNT; n++) begin
			check_true(!busy && !raw_l, "extra start launched a second packet");
			step();
		end
		check_reply(10);
		key = rand_byte();  // New key for the full-size packet
		load_packet(MSG_MAX);
		run_packet(MSG_MAX, -1);
		check_reply(MSG_MAX);
		check_true(got_csum, "csum_valid never pulsed on the full packet");
		check_value("csum", csum_got, model_sum(MSG_MAX));
		end_test("back_to_back");
	endtask

	initial begin
		lfsr = 32'hfddaee2c;
		errors = 0;
		test_errs = 0;
		tests = 0;
		reset = 1'b1;
		start = 1'b0;
		data_len = '0;
		load_we = 1'b0;
		load_addr = '0;
		load_data = '0;
		key = '0;
		rd_addr = '0;
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;
		test_reset();
		test_framing();
		test_reply();
		test_latency();
		test_checksum();
		test_back_to_back();
		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// ==== sources.f ====
common/client_pkg.sv
common/frame_pkg.sv
framer/packet_framer.sv
rtl/payload_scrambler.sv
rtl/reply_capture.sv
rtl/client_loop_top.sv
dv/client_loop_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the client loop testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f sources.f \
	--top-module client_loop_tb -o client_loop_sim
output=$(./obj_dir/client_loop_sim)
echo "$output"
if echo "$output" | grep -qx "Finished with no errors"; then
	exit 0
fi
exit 1
